/* rtl/stat_pkg.sv */
// Statistics package with counter widths, statistic ids, frame limits and event offsets
package stat_pkg;

    // Record and counter widths
    localparam int STAT_INC_W   = 16;
    localparam int STAT_ACC_W   = 24;
    localparam int STAT_COUNT_W = 64;
    localparam int STAT_ID_W    = 4;

    // Counter layout, 8 events per port over 2 ports
    localparam int STAT_PER_PORT = 8;
    localparam int STAT_COUNT    = 16;

    // Frame length limits
    localparam int FRAME_LEN_W   = 16;
    localparam int MIN_FRAME_LEN = 64;
    localparam int MAX_PKT_LEN   = 9218;

    // Event offset within a port's id range
    typedef enum logic [2:0] {
        EV_RX_PKT_GOOD = 3'd0,
        EV_RX_PKT_BAD  = 3'd1,
        EV_RX_BYTE     = 3'd2,
        EV_RX_RUNT     = 3'd3,
        EV_RX_OVERSIZE = 3'd4,
        EV_TX_PKT      = 3'd5,
        EV_TX_BYTE     = 3'd6,
        EV_TX_OVERSIZE = 3'd7
    } stat_event_t;

    typedef logic [STAT_ID_W-1:0]    stat_id_t;
    typedef logic [STAT_INC_W-1:0]   stat_inc_t;
    typedef logic [STAT_COUNT_W-1:0] stat_count_t;
    typedef logic [FRAME_LEN_W-1:0]  frame_len_t;

endpackage

/* rtl/axil_pkg.sv */
// AXI4-Lite package with bus widths, response codes and read FSM states
package axil_pkg;

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;

    // Only OKAY and SLVERR are ever returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // Read channel FSM
    typedef enum logic [1:0] {
        RD_IDLE   = 2'd0,
        RD_LOOKUP = 2'd1,
        RD_RESP   = 2'd2
    } axil_rd_state_t;

endpackage

/* rtl/port_stat_collector.sv */
// Port statistics collector that sorts frames into events and emits increment records
module port_stat_collector #(
    parameter int STAT_ID_BASE = 0
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 rx_frame,
    input  wire logic                 rx_bad_fcs,
    input  wire stat_pkg::frame_len_t rx_len,
    input  wire logic                 tx_frame,
    input  wire stat_pkg::frame_len_t tx_len,
    output logic                      rec_valid,
    output stat_pkg::stat_id_t        rec_id,
    output stat_pkg::stat_inc_t       rec_inc,
    input  wire logic                 rec_ready
);

    import stat_pkg::*;

    logic                  rx_frame_q;
    logic                  tx_frame_q;
    logic                  rx_bad_q;
    frame_len_t            rx_len_q;
    frame_len_t            tx_len_q;
    logic                  rx_runt;
    logic                  rx_over;
    logic                  tx_over;
    logic [STAT_ACC_W-1:0] acc [STAT_PER_PORT];
    logic [STAT_ACC_W-1:0] delta [STAT_PER_PORT];
    logic [STAT_ACC_W-1:0] sub [STAT_PER_PORT];
    stat_event_t           scan_ptr;
    stat_event_t           rec_ev;
    logic                  load;

    // Frame sampling stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_frame_q <= 1'b0;
            tx_frame_q <= 1'b0;
        end else begin
            rx_frame_q <= rx_frame;
            tx_frame_q <= tx_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_frame) begin
            rx_bad_q <= rx_bad_fcs;
            rx_len_q <= rx_len;
        end
        if (tx_frame) begin
            tx_len_q <= tx_len;
        end
    end

    assign rx_runt = rx_len_q < frame_len_t'(MIN_FRAME_LEN);
    assign rx_over = rx_len_q > frame_len_t'(MAX_PKT_LEN);
    assign tx_over = tx_len_q > frame_len_t'(MAX_PKT_LEN);

    // Increments contributed by the sampled frame
    always_comb begin
        delta[EV_RX_PKT_GOOD] = STAT_ACC_W'(rx_frame_q && !rx_bad_q);
        delta[EV_RX_PKT_BAD]  = STAT_ACC_W'(rx_frame_q && rx_bad_q);
        delta[EV_RX_BYTE]     = rx_frame_q ? STAT_ACC_W'(rx_len_q) : '0;
        delta[EV_RX_RUNT]     = STAT_ACC_W'(rx_frame_q && rx_runt);
        delta[EV_RX_OVERSIZE] = STAT_ACC_W'(rx_frame_q && rx_over);
        delta[EV_TX_PKT]      = STAT_ACC_W'(tx_frame_q);
        delta[EV_TX_BYTE]     = tx_frame_q ? STAT_ACC_W'(tx_len_q) : '0;
        delta[EV_TX_OVERSIZE] = STAT_ACC_W'(tx_frame_q && tx_over);
    end

    // Amount handed off by the record leaving this cycle
    always_comb begin
        for (int i = 0; i < STAT_PER_PORT; i++) begin
            sub[i] = '0;
        end
        if (rec_valid && rec_ready) begin
            sub[rec_ev] = STAT_ACC_W'(rec_inc);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < STAT_PER_PORT; i++) begin
                acc[i] <= '0;
            end
        end else begin
            for (int i = 0; i < STAT_PER_PORT; i++) begin
                acc[i] <= acc[i] + delta[i] - sub[i];
            end
        end
    end

    // Scan advances only when the output slot is empty or draining
    assign load = !rec_valid || rec_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
            scan_ptr  <= EV_RX_PKT_GOOD;
        end else if (load) begin
            rec_valid <= (acc[scan_ptr] != '0);
            scan_ptr  <= stat_event_t'(3'(scan_ptr + 1'b1));
        end
    end

    // Saturate at the record increment width
    always_ff @(posedge clk) begin
        if (load) begin
            rec_ev <= scan_ptr;
            if (|acc[scan_ptr][STAT_ACC_W-1:STAT_INC_W]) begin
                rec_inc <= '1;
            end else begin
                rec_inc <= acc[scan_ptr][STAT_INC_W-1:0];
            end
        end
    end

    assign rec_id = stat_id_t'(STAT_ID_BASE) + stat_id_t'(rec_ev);

endmodule

/* rtl/stat_arb_mux.sv */
// Round-robin arbiter merging two record streams into one registered stream
module stat_arb_mux (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                s0_rec_valid,
    input  wire stat_pkg::stat_id_t  s0_rec_id,
    input  wire stat_pkg::stat_inc_t s0_rec_inc,
    output logic                     s0_rec_ready,
    input  wire logic                s1_rec_valid,
    input  wire stat_pkg::stat_id_t  s1_rec_id,
    input  wire stat_pkg::stat_inc_t s1_rec_inc,
    output logic                     s1_rec_ready,
    output logic                     m_rec_valid,
    output stat_pkg::stat_id_t       m_rec_id,
    output stat_pkg::stat_inc_t      m_rec_inc,
    input  wire logic                m_rec_ready
);

    logic last_grant;
    logic grant0;
    logic grant1;
    logic out_free;

    assign out_free = !m_rec_valid || m_rec_ready;

    // On a tie, port 1 wins only if port 0 was served last
    assign grant1 = s1_rec_valid && (!s0_rec_valid || !last_grant);
    assign grant0 = s0_rec_valid && !grant1;

    assign s0_rec_ready = grant0 && out_free;
    assign s1_rec_ready = grant1 && out_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_rec_valid <= 1'b0;
            last_grant  <= 1'b1;
        end else if (out_free) begin
            m_rec_valid <= grant0 || grant1;
            if (grant0 || grant1) begin
                last_grant <= grant1;
            end
        end
    end

    // Output register refills in the same cycle it drains
    always_ff @(posedge clk) begin
        if (out_free && grant1) begin
            m_rec_id  <= s1_rec_id;
            m_rec_inc <= s1_rec_inc;
        end else if (out_free && grant0) begin
            m_rec_id  <= s0_rec_id;
            m_rec_inc <= s0_rec_inc;
        end
    end

endmodule

/* rtl/stat_counter_bank.sv */
// Statistics counter bank with 64-bit counters and an AXI4-Lite read port
module stat_counter_bank (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 rec_valid,
    input  wire stat_pkg::stat_id_t   rec_id,
    input  wire stat_pkg::stat_inc_t  rec_inc,
    output logic                      rec_ready,
    input  wire axil_pkg::axil_addr_t s_axil_araddr,
    input  wire logic                 s_axil_arvalid,
    output logic                      s_axil_arready,
    output axil_pkg::axil_data_t      s_axil_rdata,
    output axil_pkg::axil_resp_t      s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  wire logic                 s_axil_rready
);

    import stat_pkg::*;
    import axil_pkg::*;

    stat_count_t    cnt [STAT_COUNT];
    logic           upd_valid;
    stat_id_t       upd_id;
    stat_inc_t      upd_inc;
    axil_rd_state_t rd_state;
    axil_addr_t     araddr_q;
    stat_count_t    rd_cnt;
    logic           rd_err;

    // Counter bank never stalls the record stream
    assign rec_ready = 1'b1;

    // Record stage ahead of the 64-bit adder
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= rec_valid && rec_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (rec_valid) begin
            upd_id  <= rec_id;
            upd_inc <= rec_inc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < STAT_COUNT; i++) begin
                cnt[i] <= '0;
            end
        end else if (upd_valid) begin
            cnt[upd_id] <= cnt[upd_id] + STAT_COUNT_W'(upd_inc);
        end
    end

    // Eight bytes per counter, anything past the last one or unaligned is an error
    assign rd_err = (araddr_q >= axil_addr_t'(STAT_COUNT * 8)) || (araddr_q[1:0] != 2'b00);
    assign rd_cnt = cnt[stat_id_t'(araddr_q >> 3)];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state       <= RD_IDLE;
            s_axil_arready <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (s_axil_arvalid && s_axil_arready) begin
                        s_axil_arready <= 1'b0;
                        rd_state       <= RD_LOOKUP;
                    end else begin
                        s_axil_arready <= 1'b1;
                    end
                end
                RD_LOOKUP: begin
                    rd_state <= RD_RESP;
                end
                RD_RESP: begin
                    if (s_axil_rready) begin
                        s_axil_arready <= 1'b1;
                        rd_state       <= RD_IDLE;
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // Read data is captured in lookup and held through the response
    always_ff @(posedge clk) begin
        if (s_axil_arvalid && s_axil_arready) begin
            araddr_q <= s_axil_araddr;
        end
        if (rd_state == RD_LOOKUP) begin
            if (rd_err) begin
                s_axil_rdata <= '0;
                s_axil_rresp <= RESP_SLVERR;
            end else begin
                s_axil_rdata <= araddr_q[2] ? rd_cnt[AXIL_DATA_W +: AXIL_DATA_W]
                                            : rd_cnt[0 +: AXIL_DATA_W];
                s_axil_rresp <= RESP_OKAY;
            end
        end
    end

    assign s_axil_rvalid = (rd_state == RD_RESP);

endmodule

/* rtl/eth_stats_core.sv */
// Ethernet statistics core joining two port collectors into one counter bank
module eth_stats_core (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 p0_rx_frame,
    input  wire logic                 p0_rx_bad_fcs,
    input  wire stat_pkg::frame_len_t p0_rx_len,
    input  wire logic                 p0_tx_frame,
    input  wire stat_pkg::frame_len_t p0_tx_len,
    input  wire logic                 p1_rx_frame,
    input  wire logic                 p1_rx_bad_fcs,
    input  wire stat_pkg::frame_len_t p1_rx_len,
    input  wire logic                 p1_tx_frame,
    input  wire stat_pkg::frame_len_t p1_tx_len,
    input  wire axil_pkg::axil_addr_t s_axil_araddr,
    input  wire logic                 s_axil_arvalid,
    output wire logic                 s_axil_arready,
    output wire axil_pkg::axil_data_t s_axil_rdata,
    output wire axil_pkg::axil_resp_t s_axil_rresp,
    output wire logic                 s_axil_rvalid,
    input  wire logic                 s_axil_rready
);

    import stat_pkg::*;

    logic      p0_rec_valid;
    stat_id_t  p0_rec_id;
    stat_inc_t p0_rec_inc;
    logic      p0_rec_ready;
    logic      p1_rec_valid;
    stat_id_t  p1_rec_id;
    stat_inc_t p1_rec_inc;
    logic      p1_rec_ready;
    logic      mux_rec_valid;
    stat_id_t  mux_rec_id;
    stat_inc_t mux_rec_inc;
    logic      mux_rec_ready;

    port_stat_collector #(.STAT_ID_BASE(0)) i_port0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_frame   (p0_rx_frame),
        .rx_bad_fcs (p0_rx_bad_fcs),
        .rx_len     (p0_rx_len),
        .tx_frame   (p0_tx_frame),
        .tx_len     (p0_tx_len),
        .rec_valid  (p0_rec_valid),
        .rec_id     (p0_rec_id),
        .rec_inc    (p0_rec_inc),
        .rec_ready  (p0_rec_ready)
    );

    // Port 1 ids start right after port 0's block
    port_stat_collector #(.STAT_ID_BASE(STAT_PER_PORT)) i_port1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_frame   (p1_rx_frame),
        .rx_bad_fcs (p1_rx_bad_fcs),
        .rx_len     (p1_rx_len),
        .tx_frame   (p1_tx_frame),
        .tx_len     (p1_tx_len),
        .rec_valid  (p1_rec_valid),
        .rec_id     (p1_rec_id),
        .rec_inc    (p1_rec_inc),
        .rec_ready  (p1_rec_ready)
    );

    stat_arb_mux i_mux (
        .clk          (clk),
        .rst_n        (rst_n),
        .s0_rec_valid (p0_rec_valid),
        .s0_rec_id    (p0_rec_id),
        .s0_rec_inc   (p0_rec_inc),
        .s0_rec_ready (p0_rec_ready),
        .s1_rec_valid (p1_rec_valid),
        .s1_rec_id    (p1_rec_id),
        .s1_rec_inc   (p1_rec_inc),
        .s1_rec_ready (p1_rec_ready),
        .m_rec_valid  (mux_rec_valid),
        .m_rec_id     (mux_rec_id),
        .m_rec_inc    (mux_rec_inc),
        .m_rec_ready  (mux_rec_ready)
    );

    stat_counter_bank i_bank (
        .clk            (clk),
        .rst_n          (rst_n),
        .rec_valid      (mux_rec_valid),
        .rec_id         (mux_rec_id),
        .rec_inc        (mux_rec_inc),
        .rec_ready      (mux_rec_ready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready)
    );

endmodule

/* verif/eth_stats_assert.sv */
// Bound protocol checks for a record stream and the AXI4-Lite read response channel
module eth_stats_assert #(
    parameter int ID_BASE  = 0,
    parameter int ID_COUNT = stat_pkg::STAT_COUNT
) (
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire logic                 rec_valid,
    input wire logic                 rec_ready,
    input wire stat_pkg::stat_id_t   rec_id,
    input wire stat_pkg::stat_inc_t  rec_inc,
    input wire logic                 rvalid,
    input wire logic                 rready,
    input wire axil_pkg::axil_data_t rdata,
    input wire axil_pkg::axil_resp_t rresp
);

    timeunit 1ns;
    timeprecision 1ps;

    import stat_pkg::*;

    int fail_cnt = 0;

    // A stalled record keeps its payload until accepted
    rec_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rec_valid && !rec_ready |=> rec_valid && $stable(rec_id) && $stable(rec_inc))
    else begin
        fail_cnt++;
        $error("record changed while stalled");
    end

    // Each stream only carries ids from its own block
    rec_id_range: assert property (@(posedge clk) disable iff (!rst_n)
        rec_valid |-> rec_id >= ID_BASE && rec_id < ID_BASE + ID_COUNT)
    else begin
        fail_cnt++;
        $error("record id %0d outside its id range", rec_id);
    end

    // Read response held with stable data until taken
    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        fail_cnt++;
        $error("read response dropped or changed before rready");
    end

endmodule

// Collector streams at the arbiter inputs, where back-pressure actually occurs
bind stat_arb_mux eth_stats_assert #(
    .ID_BASE  (0),
    .ID_COUNT (stat_pkg::STAT_PER_PORT)
) i_s0_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .rec_valid (s0_rec_valid),
    .rec_ready (s0_rec_ready),
    .rec_id    (s0_rec_id),
    .rec_inc   (s0_rec_inc),
    .rvalid    (1'b0),
    .rready    (1'b0),
    .rdata     (32'h0),
    .rresp     (axil_pkg::RESP_OKAY)
);

bind stat_arb_mux eth_stats_assert #(
    .ID_BASE  (stat_pkg::STAT_PER_PORT),
    .ID_COUNT (stat_pkg::STAT_PER_PORT)
) i_s1_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .rec_valid (s1_rec_valid),
    .rec_ready (s1_rec_ready),
    .rec_id    (s1_rec_id),
    .rec_inc   (s1_rec_inc),
    .rvalid    (1'b0),
    .rready    (1'b0),
    .rdata     (32'h0),
    .rresp     (axil_pkg::RESP_OKAY)
);

bind stat_counter_bank eth_stats_assert i_bank_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .rec_valid (rec_valid),
    .rec_ready (rec_ready),
    .rec_id    (rec_id),
    .rec_inc   (rec_inc),
    .rvalid    (s_axil_rvalid),
    .rready    (s_axil_rready),
    .rdata     (s_axil_rdata),
    .rresp     (s_axil_rresp)
);

/* verif/tb_eth_stats.sv */
// Testbench for the Ethernet statistics core, driven by frame and read commands from a file
module tb_eth_stats;

    timeunit 1ns;
    timeprecision 1ps;

    import stat_pkg::*;
    import axil_pkg::*;

    localparam string TESTS_FILE = "verif/eth_stats_tests.txt";

    logic        clk;
    logic        rst_n;
    logic        p0_rx_frame;
    logic        p0_rx_bad_fcs;
    frame_len_t  p0_rx_len;
    logic        p0_tx_frame;
    frame_len_t  p0_tx_len;
    logic        p1_rx_frame;
    logic        p1_rx_bad_fcs;
    frame_len_t  p1_rx_len;
    logic        p1_tx_frame;
    frame_len_t  p1_tx_len;
    axil_addr_t  s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    axil_data_t  s_axil_rdata;
    axil_resp_t  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;

    // Commands parsed from the tests file
    byte         cmd_kind [$];
    int          cmd_a [$];
    int          cmd_b [$];
    int          cmd_c [$];
    int          cmd_d [$];
    int          cmd_e [$];
    stat_count_t cmd_exp [$];

    int unsigned file_lines = 0;
    int unsigned cycle_limit = 0;
    int unsigned cycle_cnt = 0;
    logic [31:0] lcg_state = 32'd97031;

    eth_stats_core i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .p0_rx_frame    (p0_rx_frame),
        .p0_rx_bad_fcs  (p0_rx_bad_fcs),
        .p0_rx_len      (p0_rx_len),
        .p0_tx_frame    (p0_tx_frame),
        .p0_tx_len      (p0_tx_len),
        .p1_rx_frame    (p1_rx_frame),
        .p1_rx_bad_fcs  (p1_rx_bad_fcs),
        .p1_rx_len      (p1_rx_len),
        .p1_tx_frame    (p1_tx_frame),
        .p1_tx_len      (p1_tx_len),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Watchdog, armed once the tests file has been sized
    initial begin
        wait (cycle_limit != 0);
        wait (cycle_cnt >= cycle_limit);
        $display("Run timed out after %0d cycles before all commands finished", cycle_cnt);
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // All driving happens 10 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_count(input stat_count_t got, input stat_count_t exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s read 0x%016h, expected 0x%016h",
                     $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "wrong counter value");
        end
    endtask

    task automatic check_data(input axil_data_t got, input axil_data_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "wrong read data");
        end
    endtask

    task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s response %0d, expected %0d", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "wrong read response");
        end
    endtask

    task automatic load_tests();
        int          fd;
        string       line;
        byte         kind;
        logic        ok;
        int          a;
        int          b;
        int          c;
        int          d;
        int          e;
        stat_count_t exp;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the tests file %s", TESTS_FILE);
            $display("Some tests failed");
            $fatal(1, "missing tests file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                file_lines++;
                a = 0;
                b = 0;
                c = 0;
                d = 0;
                e = 0;
                exp = '0;
                ok = 1'b1;
                kind = (line.len() > 0) ? line[0] : 8'd0;
                if (kind == "F") begin
                    ok = ($sscanf(line, "F %d %d %d %d %d", a, b, c, d, e) == 5);
                end else if (kind == "R") begin
                    ok = ($sscanf(line, "R %d %h %d", a, exp, c) == 3);
                end else if (kind == "A") begin
                    ok = ($sscanf(line, "A %h %h %d", a, exp, c) == 3);
                end else if (kind != "D") begin
                    // Comment or blank line
                    kind = 8'd0;
                end
                if (!ok) begin
                    $display("Line %0d of the tests file cannot be parsed", file_lines);
                    $display("Some tests failed");
                    $fatal(1, "malformed tests file");
                end else if (kind != 8'd0) begin
                    cmd_kind.push_back(kind);
                    cmd_a.push_back(a);
                    cmd_b.push_back(b);
                    cmd_c.push_back(c);
                    cmd_d.push_back(d);
                    cmd_e.push_back(e);
                    cmd_exp.push_back(exp);
                end
            end
            $fclose(fd);
            cycle_limit = 200 * file_lines + 100;
        end
    endtask

    task automatic clear_strobes();
        p0_rx_frame = 1'b0;
        p0_tx_frame = 1'b0;
        p1_rx_frame = 1'b0;
        p1_tx_frame = 1'b0;
    endtask

    // Port 2 drives the same frame on both ports in one cycle
    task automatic set_strobe(input int port, input int dir, input frame_len_t len,
                              input logic bad);
        clear_strobes();
        if (port != 1) begin
            if (dir == 0) begin
                p0_rx_frame   = 1'b1;
                p0_rx_bad_fcs = bad;
                p0_rx_len     = len;
            end else begin
                p0_tx_frame = 1'b1;
                p0_tx_len   = len;
            end
        end
        if (port != 0) begin
            if (dir == 0) begin
                p1_rx_frame   = 1'b1;
                p1_rx_bad_fcs = bad;
                p1_rx_len     = len;
            end else begin
                p1_tx_frame = 1'b1;
                p1_tx_len   = len;
            end
        end
    endtask

    task automatic send_frames(input int port, input int dir, input int len, input int bad,
                               input int count);
        logic [31:0] gap;
        repeat (count) begin
            set_strobe(port, dir, frame_len_t'(len), bad[0]);
            step();
        end
        clear_strobes();
        gap = (next_rand() >> 16) & 32'd3;
        repeat (gap) step();
    endtask

    task automatic read_word(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        while (!s_axil_arready) step();
        step();
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid) step();
        // Hold off rready one cycle so the response must stay put
        step();
        data = s_axil_rdata;
        resp = s_axil_rresp;
        s_axil_rready = 1'b1;
        step();
        s_axil_rready = 1'b0;
    endtask

    task automatic read_counter(input int id, input stat_count_t exp, input int exp_resp);
        axil_data_t lo;
        axil_data_t hi;
        axil_resp_t r_lo;
        axil_resp_t r_hi;
        read_word(axil_addr_t'(id * 8), lo, r_lo);
        read_word(axil_addr_t'(id * 8 + 4), hi, r_hi);
        check_resp(r_lo, axil_resp_t'(exp_resp), $sformatf("counter %0d low word", id));
        check_resp(r_hi, axil_resp_t'(exp_resp), $sformatf("counter %0d high word", id));
        check_count({hi, lo}, exp, $sformatf("counter %0d", id));
    endtask

    task automatic read_raw(input int addr, input stat_count_t exp, input int exp_resp);
        axil_data_t data;
        axil_resp_t resp;
        read_word(axil_addr_t'(addr), data, resp);
        check_resp(resp, axil_resp_t'(exp_resp), $sformatf("address 0x%02h", addr));
        check_data(data, exp[AXIL_DATA_W-1:0], $sformatf("address 0x%02h", addr));
    endtask

    function automatic int assertion_failures();
        return i_dut.i_mux.i_s0_assert.fail_cnt + i_dut.i_mux.i_s1_assert.fail_cnt
             + i_dut.i_bank.i_bank_assert.fail_cnt;
    endfunction

    // Stop at the first protocol assertion failure
    always @(negedge clk) begin
        if (assertion_failures() != 0) begin
            $display("A protocol assertion failed before %0t", $time);
            $display("Some tests failed");
            $fatal(1, "protocol assertion failure");
        end
    end

    initial begin
        rst_n          = 1'b0;
        p0_rx_bad_fcs  = 1'b0;
        p0_rx_len      = '0;
        p0_tx_len      = '0;
        p1_rx_bad_fcs  = 1'b0;
        p1_rx_len      = '0;
        p1_tx_len      = '0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        clear_strobes();
        load_tests();
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        step();
        for (int i = 0; i < cmd_kind.size(); i++) begin
            case (cmd_kind[i])
                "F": send_frames(cmd_a[i], cmd_b[i], cmd_c[i], cmd_d[i], cmd_e[i]);
                "D": repeat (64) step();
                "R": read_counter(cmd_a[i], cmd_exp[i], cmd_c[i]);
                "A": read_raw(cmd_a[i], cmd_exp[i], cmd_c[i]);
                default: step();
            endcase
        end
        if (assertion_failures() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%0d protocol assertions failed during the run", assertion_failures());
            $display("Some tests failed");
            $fatal(1, "protocol assertion failure");
        end
    end

endmodule

/* verif/eth_stats_tests.txt */
# F port dir len bad count : frames back to back, port 2 is both ports, dir 0 rx 1 tx
# D : drain 64 cycles  R id exp resp : 64-bit counter  A addr exp resp : one word, hex
R 0 0 0
R 7 0 0
R 15 0 0
F 0 0 100 0 1
F 0 0 200 0 1
F 0 0 150 1 1
D
R 0 2 0
R 1 1 0
R 2 1c2 0
F 0 0 40 0 1
F 0 0 9300 1 1
D
R 3 1 0
R 4 1 0
R 0 3 0
R 1 2 0
R 2 263e 0
F 1 1 1000 0 1
F 1 1 9500 0 1
D
R 13 2 0
R 14 2904 0
R 15 1 0
R 5 0 0
R 2 263e 0
F 2 0 64 0 4
F 2 1 128 0 4
D
R 0 7 0
R 2 273e 0
R 3 1 0
R 5 4 0
R 6 200 0
R 8 4 0
R 10 100 0
R 13 6 0
R 14 2b04 0
A 80 0 2
A 3 0 2
A 70 2b04 0
A 74 0 0

/* tb.f */
rtl/stat_pkg.sv
rtl/axil_pkg.sv
rtl/port_stat_collector.sv
rtl/stat_arb_mux.sv
rtl/stat_counter_bank.sv
rtl/eth_stats_core.sv
verif/eth_stats_assert.sv
verif/tb_eth_stats.sv
